/* design/fabric_pkg.sv */
// fabric_pkg
// shared widths, response and target codes, address map and
// control register offsets for the tile memory-side fabric

package fabric_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [63:0] flit_t;

  // axi response codes
  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2,
    DECERR = 2'd3
  } resp_e;

  // decoded destination of one access
  typedef enum logic [1:0] {
    TGT_NOC  = 2'd0,
    TGT_CTRL = 2'd1,
    TGT_NONE = 2'd2
  } target_e;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////
  localparam addr_t DRAM_BASE   = 32'h8000_0000;
  localparam addr_t DRAM_LENGTH = 32'h4000_0000;
  localparam addr_t CTRL_BASE   = 32'hD000_0000;
  localparam addr_t CTRL_LENGTH = 32'h0000_1000;

  // register offsets inside the ctrl window
  localparam addr_t REG_EXIT      = 32'h00;
  localparam addr_t REG_DRAM_BASE = 32'h08;
  localparam addr_t REG_DRAM_END  = 32'h10;
  localparam addr_t REG_HW_CNT_EN = 32'h18;
  localparam addr_t REG_EVENT     = 32'h20;

  // noc header command field
  localparam logic [7:0] FLIT_CMD_WRITE = 8'd1;
  localparam logic [7:0] FLIT_CMD_READ  = 8'd2;

endpackage : fabric_pkg

/* design/wake_reset_gen.sv */
// wake_reset_gen
// holds the system in reset after power-on until the wake-up counter
// saturates, then releases it through a two-flop synchronizer

`timescale 1ns/100ps

module wake_reset_gen #(
  parameter int WAKE_CNT_WIDTH = 16
) (
  input  logic clk_i,
  input  logic reset_l,
  output logic sys_rst_l_o
);

  logic [WAKE_CNT_WIDTH-1:0] wake_cnt_q;
  logic                      pre_rst_l;
  logic [1:0]                sync_q;

  // count up and stop once the top bit sets
  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      wake_cnt_q <= '0;
    end else if (!wake_cnt_q[WAKE_CNT_WIDTH-1]) begin
      wake_cnt_q <= wake_cnt_q + 1'b1;
    end
  end

  // gated reset before synchronization
  assign pre_rst_l = wake_cnt_q[WAKE_CNT_WIDTH-1] & reset_l;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], pre_rst_l};
    end
  end

  assign sys_rst_l_o = sync_q[1];

  // released system reset never drops back while the pin reset stays high
  a_sys_rst_holds: assert property (
    @(posedge clk_i) disable iff (!reset_l) sys_rst_l_o |=> sys_rst_l_o
  );

endmodule : wake_reset_gen

/* design/axil_addr_decode.sv */
// axil_addr_decode
// accepts one axi4-lite request at a time, latches it and routes it
// by address to the noc bridge, the control registers or an error

`timescale 1ns/100ps

module axil_addr_decode
  import fabric_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_l,
  // write address and data
  input  addr_t s_awaddr_i,
  input  logic  s_awvalid_i,
  output logic  s_awready_o,
  input  data_t s_wdata_i,
  input  strb_t s_wstrb_i,
  input  logic  s_wvalid_i,
  output logic  s_wready_o,
  // read address
  input  addr_t s_araddr_i,
  input  logic  s_arvalid_i,
  output logic  s_arready_o,
  // request to the targets
  output logic  ctrl_req_o,
  output logic  noc_req_o,
  output logic  dec_err_o,
  output logic  req_write_o,
  output addr_t req_addr_o,
  output data_t req_wdata_o,
  output strb_t req_strb_o,
  input  logic  free_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WACK,
    ST_RACK,
    ST_BUSY
  } dec_state_e;

  dec_state_e state_q;
  logic       hs;
  addr_t      hs_addr;
  target_e    tgt;

  // ready is high for the single cycle of the handshake
  assign s_awready_o = (state_q == ST_WACK);
  assign s_wready_o  = (state_q == ST_WACK);
  assign s_arready_o = (state_q == ST_RACK);

  assign hs      = (state_q == ST_WACK) || (state_q == ST_RACK);
  assign hs_addr = (state_q == ST_WACK) ? s_awaddr_i : s_araddr_i;

  ////////////////////////////////////////
  // window compare
  ////////////////////////////////////////
  always_comb begin
    if ((hs_addr - DRAM_BASE) < DRAM_LENGTH) begin
      tgt = TGT_NOC;
    end else if ((hs_addr - CTRL_BASE) < CTRL_LENGTH) begin
      tgt = TGT_CTRL;
    end else begin
      tgt = TGT_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q    <= ST_IDLE;
      ctrl_req_o <= 1'b0;
      noc_req_o  <= 1'b0;
      dec_err_o  <= 1'b0;
    end else begin
      ctrl_req_o <= hs && (tgt == TGT_CTRL);
      noc_req_o  <= hs && (tgt == TGT_NOC);
      dec_err_o  <= hs && (tgt == TGT_NONE);
      case (state_q)
        ST_IDLE: begin
          // writes win over reads
          if (s_awvalid_i && s_wvalid_i) begin
            state_q <= ST_WACK;
          end else if (s_arvalid_i) begin
            state_q <= ST_RACK;
          end
        end
        ST_WACK, ST_RACK: state_q <= ST_BUSY;
        default: begin
          if (free_i) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // request payload, held until the response is taken
  always_ff @(posedge clk_i) begin
    if (hs) begin
      req_write_o <= (state_q == ST_WACK);
      req_addr_o  <= (tgt == TGT_CTRL) ? (hs_addr - CTRL_BASE) : hs_addr;
      req_wdata_o <= (state_q == ST_WACK) ? s_wdata_i : '0;
      req_strb_o  <= (state_q == ST_WACK) ? s_wstrb_i : '0;
    end
  end

  a_one_ready: assert property (
    @(posedge clk_i) disable iff (!reset_l) !(s_awready_o && s_arready_o)
  );

endmodule : axil_addr_decode

/* design/ctrl_regs.sv */
// ctrl_regs
// control and status registers: exit value, hardware counter enable,
// event trigger and readback of the dram window bounds

`timescale 1ns/100ps

module ctrl_regs
  import fabric_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_l,
  input  logic  ctrl_req_i,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  output logic  ctrl_done_o,
  output data_t ctrl_rdata_o,
  output resp_e ctrl_resp_o,
  output data_t exit_o,
  output logic  hw_cnt_en_o,
  output logic  event_trigger_o
);

  localparam data_t DRAM_BASE_WORD = data_t'(DRAM_BASE);
  localparam data_t DRAM_END_WORD  = data_t'(DRAM_BASE) + data_t'(DRAM_LENGTH);

  data_t sel_rdata;
  resp_e sel_resp;
  logic  wr_ok;

  ////////////////////////////////////////
  // offset decode
  ////////////////////////////////////////
  always_comb begin
    sel_rdata = '0;
    sel_resp  = OKAY;
    case (req_addr_i)
      REG_EXIT:      sel_rdata = exit_o;
      REG_HW_CNT_EN: sel_rdata = data_t'(hw_cnt_en_o);
      // write-only, reads as zero
      REG_EVENT:     sel_rdata = '0;
      REG_DRAM_BASE: begin
        sel_rdata = DRAM_BASE_WORD;
        if (req_write_i) begin
          sel_resp = SLVERR;
        end
      end
      REG_DRAM_END: begin
        sel_rdata = DRAM_END_WORD;
        if (req_write_i) begin
          sel_resp = SLVERR;
        end
      end
      default: sel_resp = SLVERR;
    endcase
  end

  assign wr_ok = ctrl_req_i && req_write_i && (sel_resp == OKAY);

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      exit_o          <= '0;
      hw_cnt_en_o     <= 1'b0;
      event_trigger_o <= 1'b0;
      ctrl_done_o     <= 1'b0;
    end else begin
      ctrl_done_o     <= ctrl_req_i;
      event_trigger_o <= wr_ok && (req_addr_i == REG_EVENT) && req_wdata_i[0];
      if (wr_ok && (req_addr_i == REG_EXIT)) begin
        // byte merge under the strobes
        for (int b = 0; b < 8; b++) begin
          if (req_strb_i[b]) begin
            exit_o[8*b +: 8] <= req_wdata_i[8*b +: 8];
          end
        end
      end
      if (wr_ok && (req_addr_i == REG_HW_CNT_EN)) begin
        hw_cnt_en_o <= req_wdata_i[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_req_i) begin
      ctrl_rdata_o <= req_write_i ? '0 : sel_rdata;
      ctrl_resp_o  <= sel_resp;
    end
  end

endmodule : ctrl_regs

/* design/noc_bridge.sv */
// noc_bridge
// turns one request into a header flit, plus a data flit for writes,
// then waits for the single reply flit from the noc

`timescale 1ns/100ps

module noc_bridge
  import fabric_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_l,
  input  logic  noc_req_i,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  data_t req_wdata_i,
  input  strb_t req_strb_i,
  output logic  noc_done_o,
  output data_t noc_rdata_o,
  // outgoing flits
  output logic  noc_valid_o,
  output flit_t noc_data_o,
  input  logic  noc_ready_i,
  // incoming flits
  input  logic  noc_valid_i,
  input  flit_t noc_data_i,
  output logic  noc_ready_o
);

  typedef enum logic [1:0] {
    NB_IDLE,
    NB_HDR,
    NB_DATA,
    NB_WAIT
  } nb_state_e;

  nb_state_e  state_q;
  logic [7:0] cmd;
  flit_t      hdr_flit;

  // header: cmd, strobes, zero pad, address
  assign cmd      = req_write_i ? FLIT_CMD_WRITE : FLIT_CMD_READ;
  assign hdr_flit = {cmd, req_strb_i, 16'h0000, req_addr_i};

  // request fields are held by the decoder, so the flit stays stable
  assign noc_valid_o = (state_q == NB_HDR) || (state_q == NB_DATA);
  assign noc_data_o  = (state_q == NB_DATA) ? flit_t'(req_wdata_i) : hdr_flit;
  assign noc_ready_o = (state_q == NB_WAIT);

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      state_q    <= NB_IDLE;
      noc_done_o <= 1'b0;
    end else begin
      noc_done_o <= 1'b0;
      case (state_q)
        NB_IDLE: begin
          if (noc_req_i) begin
            state_q <= NB_HDR;
          end
        end
        NB_HDR: begin
          if (noc_ready_i) begin
            state_q <= req_write_i ? NB_DATA : NB_WAIT;
          end
        end
        NB_DATA: begin
          if (noc_ready_i) begin
            state_q <= NB_WAIT;
          end
        end
        default: begin
          // reply flit, acknowledge or read data
          if (noc_valid_i) begin
            state_q    <= NB_IDLE;
            noc_done_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // write acks carry nothing useful
  always_ff @(posedge clk_i) begin
    if ((state_q == NB_WAIT) && noc_valid_i && !req_write_i) begin
      noc_rdata_o <= data_t'(noc_data_i);
    end
  end

  a_flit_stable: assert property (
    @(posedge clk_i) disable iff (!reset_l)
      (noc_valid_o && !noc_ready_i) |=> $stable(noc_data_o)
  );

endmodule : noc_bridge

/* design/axil_resp_stage.sv */
// axil_resp_stage
// registers the finished response and holds it on B or R until the
// master takes it, then frees the decoder for the next request

`timescale 1ns/100ps

module axil_resp_stage
  import fabric_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_l,
  input  logic  req_write_i,
  input  logic  ctrl_done_i,
  input  data_t ctrl_rdata_i,
  input  resp_e ctrl_resp_i,
  input  logic  noc_done_i,
  input  data_t noc_rdata_i,
  input  logic  dec_err_i,
  // write response
  output resp_e s_bresp_o,
  output logic  s_bvalid_o,
  input  logic  s_bready_i,
  // read data
  output data_t s_rdata_o,
  output resp_e s_rresp_o,
  output logic  s_rvalid_o,
  input  logic  s_rready_i,
  output logic  free_o
);

  logic  fin;
  resp_e resp_q;

  assign fin = ctrl_done_i | noc_done_i | dec_err_i;

  always_ff @(posedge clk_i or negedge reset_l) begin
    if (!reset_l) begin
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
    end else begin
      if (s_bvalid_o && s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
      if (s_rvalid_o && s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
      if (fin) begin
        s_bvalid_o <= req_write_i;
        s_rvalid_o <= !req_write_i;
      end
    end
  end

  // response payload, decode errors return zero data
  always_ff @(posedge clk_i) begin
    if (fin) begin
      if (noc_done_i) begin
        s_rdata_o <= noc_rdata_i;
        resp_q    <= OKAY;
      end else if (ctrl_done_i) begin
        s_rdata_o <= ctrl_rdata_i;
        resp_q    <= ctrl_resp_i;
      end else begin
        s_rdata_o <= '0;
        resp_q    <= DECERR;
      end
    end
  end

  assign s_bresp_o = resp_q;
  assign s_rresp_o = resp_q;
  assign free_o    = (s_bvalid_o && s_bready_i) || (s_rvalid_o && s_rready_i);

  a_one_resp: assert property (
    @(posedge clk_i) disable iff (!reset_l) !(s_bvalid_o && s_rvalid_o)
  );

endmodule : axil_resp_stage

/* design/tile_fabric_top.sv */
// tile_fabric_top
// memory-side fabric of the tile: delayed power-on reset, axi4-lite
// decode, control registers, noc bridge and response return

`timescale 1ns/100ps

module tile_fabric_top
  import fabric_pkg::*;
#(
  parameter int WAKE_CNT_WIDTH = 16
) (
  input  logic  clk_i,
  input  logic  reset_l,
  output logic  sys_rst_l_o,
  // axi4-lite slave
  input  addr_t s_awaddr_i,
  input  logic  s_awvalid_i,
  output logic  s_awready_o,
  input  data_t s_wdata_i,
  input  strb_t s_wstrb_i,
  input  logic  s_wvalid_i,
  output logic  s_wready_o,
  output resp_e s_bresp_o,
  output logic  s_bvalid_o,
  input  logic  s_bready_i,
  input  addr_t s_araddr_i,
  input  logic  s_arvalid_i,
  output logic  s_arready_o,
  output data_t s_rdata_o,
  output resp_e s_rresp_o,
  output logic  s_rvalid_o,
  input  logic  s_rready_i,
  // noc
  output logic  noc_valid_o,
  output flit_t noc_data_o,
  input  logic  noc_ready_i,
  input  logic  noc_valid_i,
  input  flit_t noc_data_i,
  output logic  noc_ready_o,
  // side outputs
  output data_t exit_o,
  output logic  hw_cnt_en_o,
  output logic  event_trigger_o
);

  logic  ctrl_req;
  logic  noc_req;
  logic  dec_err;
  logic  req_write;
  addr_t req_addr;
  data_t req_wdata;
  strb_t req_strb;
  logic  ctrl_done;
  data_t ctrl_rdata;
  resp_e ctrl_resp;
  logic  noc_done;
  data_t noc_rdata;
  logic  free;

  wake_reset_gen #(
    .WAKE_CNT_WIDTH (WAKE_CNT_WIDTH)
  ) i_wake_reset_gen (
    .clk_i       (clk_i),
    .reset_l     (reset_l),
    .sys_rst_l_o (sys_rst_l_o)
  );

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  axil_addr_decode i_addr_decode (
    .clk_i       (clk_i),
    .reset_l     (sys_rst_l_o),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .ctrl_req_o  (ctrl_req),
    .noc_req_o   (noc_req),
    .dec_err_o   (dec_err),
    .req_write_o (req_write),
    .req_addr_o  (req_addr),
    .req_wdata_o (req_wdata),
    .req_strb_o  (req_strb),
    .free_i      (free)
  );

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////
  ctrl_regs i_ctrl_regs (
    .clk_i           (clk_i),
    .reset_l         (sys_rst_l_o),
    .ctrl_req_i      (ctrl_req),
    .req_write_i     (req_write),
    .req_addr_i      (req_addr),
    .req_wdata_i     (req_wdata),
    .req_strb_i      (req_strb),
    .ctrl_done_o     (ctrl_done),
    .ctrl_rdata_o    (ctrl_rdata),
    .ctrl_resp_o     (ctrl_resp),
    .exit_o          (exit_o),
    .hw_cnt_en_o     (hw_cnt_en_o),
    .event_trigger_o (event_trigger_o)
  );

  noc_bridge i_noc_bridge (
    .clk_i       (clk_i),
    .reset_l     (sys_rst_l_o),
    .noc_req_i   (noc_req),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_strb_i  (req_strb),
    .noc_done_o  (noc_done),
    .noc_rdata_o (noc_rdata),
    .noc_valid_o (noc_valid_o),
    .noc_data_o  (noc_data_o),
    .noc_ready_i (noc_ready_i),
    .noc_valid_i (noc_valid_i),
    .noc_data_i  (noc_data_i),
    .noc_ready_o (noc_ready_o)
  );

  ////////////////////////////////////////
  // result
  ////////////////////////////////////////
  axil_resp_stage i_resp_stage (
    .clk_i        (clk_i),
    .reset_l      (sys_rst_l_o),
    .req_write_i  (req_write),
    .ctrl_done_i  (ctrl_done),
    .ctrl_rdata_i (ctrl_rdata),
    .ctrl_resp_i  (ctrl_resp),
    .noc_done_i   (noc_done),
    .noc_rdata_i  (noc_rdata),
    .dec_err_i    (dec_err),
    .s_bresp_o    (s_bresp_o),
    .s_bvalid_o   (s_bvalid_o),
    .s_bready_i   (s_bready_i),
    .s_rdata_o    (s_rdata_o),
    .s_rresp_o    (s_rresp_o),
    .s_rvalid_o   (s_rvalid_o),
    .s_rready_i   (s_rready_i),
    .free_o       (free)
  );

endmodule : tile_fabric_top

/* verification/tb_model.svh */
// tb_model
// reference model for the fabric testbench: expected register state,
// word memory behind the noc and the typed compare tasks

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int err_cnt = 0;
int chk_cnt = 0;

// expected control register state
data_t exp_exit = '0;
logic  exp_hw   = 1'b0;

// noc side memory, one 64-bit word per entry
data_t mem [64];

initial begin
  for (int i = 0; i < 64; i++) begin
    mem[i] = {32'h5a5a_0000 ^ (i * 32'h0101_0007), ~(i * 32'h0003_0011)};
  end
end

function automatic int mem_index(input addr_t addr);
  return int'(addr[8:3]);
endfunction

// byte lanes under the strobes take the new data
function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t strb);
  data_t res;
  res = old;
  for (int b = 0; b < 8; b++) begin
    if (strb[b]) begin
      res[8*b +: 8] = wdata[8*b +: 8];
    end
  end
  return res;
endfunction

// header: command, strobes, zero pad, address
function automatic flit_t expect_header(input logic [7:0] cmd, input strb_t strb,
                                        input addr_t addr);
  return {cmd, strb, 16'h0000, addr};
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////
task automatic check_data(input string name, input data_t exp, input data_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
  end
endtask

task automatic check_resp(input string name, input resp_e exp, input resp_e act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

task automatic check_flit(input string name, input flit_t exp, input flit_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("mismatch %s: expected %h, actual %h", name, exp, act);
  end
endtask

`endif

/* verification/tb_top.sv */
// tb_top
// testbench for the tile fabric: reset release, control registers,
// event trigger, noc reads and writes and error responses

`timescale 1ns/100ps

module tb_top
  import fabric_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic  clk_i;
  logic  reset_l;
  logic  sys_rst_l_o;
  addr_t s_awaddr_i;
  logic  s_awvalid_i;
  logic  s_awready_o;
  data_t s_wdata_i;
  strb_t s_wstrb_i;
  logic  s_wvalid_i;
  logic  s_wready_o;
  resp_e s_bresp_o;
  logic  s_bvalid_o;
  logic  s_bready_i;
  addr_t s_araddr_i;
  logic  s_arvalid_i;
  logic  s_arready_o;
  data_t s_rdata_o;
  resp_e s_rresp_o;
  logic  s_rvalid_o;
  logic  s_rready_i;
  logic  noc_valid_o;
  flit_t noc_data_o;
  logic  noc_ready_i;
  logic  noc_valid_i;
  flit_t noc_data_i;
  logic  noc_ready_o;
  data_t exit_o;
  logic  hw_cnt_en_o;
  logic  event_trigger_o;

  integer seed = 32'hfb94fa5e;
  int     test_cnt = 0;
  int     ev_cnt = 0;
  logic   rst_up = 1'b0;
  logic   hold_resp = 1'b0;
  flit_t  flit_q[$];
  flit_t  hdr_log[$];
  flit_t  dat_log[$];

  `include "tb_model.svh"

  tile_fabric_top #(
    .WAKE_CNT_WIDTH (5)
  ) dut (
    .clk_i           (clk_i),
    .reset_l         (reset_l),
    .sys_rst_l_o     (sys_rst_l_o),
    .s_awaddr_i      (s_awaddr_i),
    .s_awvalid_i     (s_awvalid_i),
    .s_awready_o     (s_awready_o),
    .s_wdata_i       (s_wdata_i),
    .s_wstrb_i       (s_wstrb_i),
    .s_wvalid_i      (s_wvalid_i),
    .s_wready_o      (s_wready_o),
    .s_bresp_o       (s_bresp_o),
    .s_bvalid_o      (s_bvalid_o),
    .s_bready_i      (s_bready_i),
    .s_araddr_i      (s_araddr_i),
    .s_arvalid_i     (s_arvalid_i),
    .s_arready_o     (s_arready_o),
    .s_rdata_o       (s_rdata_o),
    .s_rresp_o       (s_rresp_o),
    .s_rvalid_o      (s_rvalid_o),
    .s_rready_i      (s_rready_i),
    .noc_valid_o     (noc_valid_o),
    .noc_data_o      (noc_data_o),
    .noc_ready_i     (noc_ready_i),
    .noc_valid_i     (noc_valid_i),
    .noc_data_i      (noc_data_i),
    .noc_ready_o     (noc_ready_o),
    .exit_o          (exit_o),
    .hw_cnt_en_o     (hw_cnt_en_o),
    .event_trigger_o (event_trigger_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] rand_word();
    rand_word = $random(seed);
  endfunction

  // one high cycle of the trigger counts once
  always @(posedge clk_i) begin
    if (event_trigger_o) begin
      ev_cnt++;
    end
  end

  always @(negedge sys_rst_l_o) begin
    if (rst_up && reset_l) begin
      err_cnt++;
      $display("system reset dropped while the reset pin stayed high");
    end
  end

  ////////////////////////////////////////
  // noc side: ready, capture, responder
  ////////////////////////////////////////
  initial begin : noc_ready_drive
    noc_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (noc_valid_o && noc_ready_i) begin
        flit_q.push_back(noc_data_o);
      end
      #1;
      noc_ready_i = (rand_word() % 4) != 0;
    end
  end

  initial begin : noc_responder
    flit_t hdr;
    flit_t dat;
    int    delay;
    int    n;
    logic  got;
    noc_valid_i = 1'b0;
    noc_data_i  = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (flit_q.size() > 1 ||
          (flit_q.size() == 1 && flit_q[0][63:56] == FLIT_CMD_READ)) begin
        hdr = flit_q.pop_front();
        hdr_log.push_back(hdr);
        if (hdr[63:56] == FLIT_CMD_WRITE) begin
          dat = flit_q.pop_front();
          dat_log.push_back(dat);
          mem[mem_index(hdr[31:0])] = merge_bytes(mem[mem_index(hdr[31:0])], dat,
                                                  hdr[55:48]);
          noc_data_i = '0;
        end else begin
          noc_data_i = mem[mem_index(hdr[31:0])];
        end
        delay = rand_word() % 6;
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        noc_valid_i = 1'b1;
        n   = 0;
        got = 1'b0;
        while (!got && n < TIMEOUT) begin
          @(posedge clk_i);
          got = noc_ready_o;
          n++;
        end
        #1;
        noc_valid_i = 1'b0;
        if (!got) begin
          err_cnt++;
          $display("timeout: the bridge never took the reply flit");
        end
      end
    end
  end

  ////////////////////////////////////////
  // axi4-lite master
  ////////////////////////////////////////
  task automatic axi_write(input string name, input addr_t addr, input data_t data,
                           input strb_t strb, output resp_e resp);
    int   n;
    logic got;
    resp        = OKAY;
    s_awaddr_i  = addr;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    n   = 0;
    got = 1'b0;
    while (!got && n < TIMEOUT) begin
      @(posedge clk_i);
      got = s_awready_o && s_wready_o;
      n++;
    end
    #1;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    if (!got) begin
      err_cnt++;
      $display("timeout: write address not accepted in %s", name);
    end
    n   = 0;
    got = 1'b0;
    while (!got && n < TIMEOUT) begin
      s_bready_i = hold_resp ? ((rand_word() % 2) != 0) : 1'b1;
      @(posedge clk_i);
      if (s_bvalid_o && s_bready_i) begin
        got  = 1'b1;
        resp = s_bresp_o;
      end
      #1;
      n++;
    end
    s_bready_i = 1'b0;
    if (!got) begin
      err_cnt++;
      $display("timeout: no write response in %s", name);
    end
  endtask

  task automatic axi_read(input string name, input addr_t addr, output data_t data,
                          output resp_e resp);
    int   n;
    logic got;
    data        = '0;
    resp        = OKAY;
    s_araddr_i  = addr;
    s_arvalid_i = 1'b1;
    n   = 0;
    got = 1'b0;
    while (!got && n < TIMEOUT) begin
      @(posedge clk_i);
      got = s_arready_o;
      n++;
    end
    #1;
    s_arvalid_i = 1'b0;
    if (!got) begin
      err_cnt++;
      $display("timeout: read address not accepted in %s", name);
    end
    n   = 0;
    got = 1'b0;
    while (!got && n < TIMEOUT) begin
      s_rready_i = hold_resp ? ((rand_word() % 2) != 0) : 1'b1;
      @(posedge clk_i);
      if (s_rvalid_o && s_rready_i) begin
        got  = 1'b1;
        data = s_rdata_o;
        resp = s_rresp_o;
      end
      #1;
      n++;
    end
    s_rready_i = 1'b0;
    if (!got) begin
      err_cnt++;
      $display("timeout: no read data in %s", name);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %-14s ok", name);
    end else begin
      $display("test %-14s FAILED with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic test_reset();
    int    errs;
    int    n;
    logic  up;
    data_t rd;
    resp_e wresp;
    resp_e rresp;
    errs = err_cnt;
    n    = 0;
    up   = 1'b0;
    // requests wait at the port while the fabric is still held in reset
    fork
      axi_write("reset write", CTRL_BASE + REG_EVENT, 64'h0, 8'hff, wresp);
      axi_read("reset read", CTRL_BASE + REG_DRAM_BASE, rd, rresp);
      begin
        while (!up && n < TIMEOUT) begin
          @(posedge clk_i);
          if (sys_rst_l_o) begin
            up = 1'b1;
          end else if (s_awready_o || s_arready_o) begin
            err_cnt++;
            $display("address ready raised while the system was in reset");
          end
          n++;
        end
        #1;
        if (!up) begin
          err_cnt++;
          $display("timeout: system reset never released");
        end
        rst_up = 1'b1;
        check_data("reset exit", '0, exit_o);
        check_data("reset idle", '0, data_t'({s_bvalid_o, s_rvalid_o, noc_valid_o,
                                              event_trigger_o, hw_cnt_en_o}));
      end
    join
    check_resp("reset write", OKAY, wresp);
    check_resp("reset read", OKAY, rresp);
    check_data("reset read", 64'h0000_0000_8000_0000, rd);
    report_test("reset", errs);
  endtask

  task automatic test_ctrl_regs();
    int    errs;
    data_t wd;
    data_t rd;
    strb_t st;
    resp_e resp;
    errs = err_cnt;
    for (int i = 0; i < 8; i++) begin
      wd = {rand_word(), rand_word()};
      st = strb_t'(rand_word());
      axi_write("exit write", CTRL_BASE + REG_EXIT, wd, st, resp);
      check_resp("exit write", OKAY, resp);
      exp_exit = merge_bytes(exp_exit, wd, st);
      axi_read("exit read", CTRL_BASE + REG_EXIT, rd, resp);
      check_data("exit read", exp_exit, rd);
      check_resp("exit read", OKAY, resp);
      check_data("exit port", exp_exit, exit_o);
      wd = {rand_word(), rand_word()};
      axi_write("hw_cnt write", CTRL_BASE + REG_HW_CNT_EN, wd, 8'hff, resp);
      check_resp("hw_cnt write", OKAY, resp);
      exp_hw = wd[0];
      axi_read("hw_cnt read", CTRL_BASE + REG_HW_CNT_EN, rd, resp);
      check_data("hw_cnt read", data_t'(exp_hw), rd);
      check_data("hw_cnt port", data_t'(exp_hw), data_t'(hw_cnt_en_o));
    end
    axi_read("dram base", CTRL_BASE + REG_DRAM_BASE, rd, resp);
    check_data("dram base", 64'h0000_0000_8000_0000, rd);
    check_resp("dram base", OKAY, resp);
    axi_read("dram end", CTRL_BASE + REG_DRAM_END, rd, resp);
    check_data("dram end", 64'h0000_0000_c000_0000, rd);
    check_resp("dram end", OKAY, resp);
    report_test("ctrl_regs", errs);
  endtask

  task automatic test_event();
    int    errs;
    data_t rd;
    resp_e resp;
    errs   = err_cnt;
    ev_cnt = 0;
    axi_write("event set", CTRL_BASE + REG_EVENT, 64'h1, 8'hff, resp);
    check_resp("event set", OKAY, resp);
    check_data("event pulses", 64'd1, data_t'(ev_cnt));
    // bit 0 clear, no pulse
    axi_write("event clear", CTRL_BASE + REG_EVENT, 64'h0, 8'hff, resp);
    check_data("event pulses", 64'd1, data_t'(ev_cnt));
    axi_read("event read", CTRL_BASE + REG_EVENT, rd, resp);
    check_data("event read", '0, rd);
    check_resp("event read", OKAY, resp);
    report_test("event", errs);
  endtask

  task automatic test_noc_writes();
    int    errs;
    addr_t addr;
    data_t wd;
    strb_t st;
    resp_e resp;
    errs      = err_cnt;
    hold_resp = 1'b1;
    for (int i = 0; i < 20; i++) begin
      addr = DRAM_BASE | (rand_word() & 32'h3fff_fff8);
      wd   = {rand_word(), rand_word()};
      st   = strb_t'(rand_word());
      hdr_log.delete();
      dat_log.delete();
      axi_write("noc write", addr, wd, st, resp);
      check_resp("noc write", OKAY, resp);
      if (hdr_log.size() != 1 || dat_log.size() != 1) begin
        err_cnt++;
        $display("noc write %0d did not send one header and one data flit", i);
      end else begin
        check_flit("noc write header", expect_header(FLIT_CMD_WRITE, st, addr), hdr_log[0]);
        check_flit("noc write data", flit_t'(wd), dat_log[0]);
      end
    end
    hold_resp = 1'b0;
    report_test("noc_writes", errs);
  endtask

  task automatic test_noc_reads();
    int    errs;
    addr_t addr;
    data_t exp;
    data_t rd;
    resp_e resp;
    errs      = err_cnt;
    hold_resp = 1'b1;
    for (int i = 0; i < 20; i++) begin
      addr = DRAM_BASE | (rand_word() & 32'h3fff_fff8);
      exp  = mem[mem_index(addr)];
      hdr_log.delete();
      axi_read("noc read", addr, rd, resp);
      check_data("noc read", exp, rd);
      check_resp("noc read", OKAY, resp);
      if (hdr_log.size() != 1) begin
        err_cnt++;
        $display("noc read %0d did not send exactly one header flit", i);
      end else begin
        check_flit("noc read header", expect_header(FLIT_CMD_READ, 8'h00, addr), hdr_log[0]);
      end
    end
    hold_resp = 1'b0;
    report_test("noc_reads", errs);
  endtask

  task automatic test_errors();
    int    errs;
    data_t rd;
    resp_e resp;
    errs = err_cnt;
    axi_read("decerr read", 32'h1000_0000, rd, resp);
    check_resp("decerr read", DECERR, resp);
    check_data("decerr read", '0, rd);
    axi_write("decerr write", 32'hF000_0000, 64'h1234, 8'hff, resp);
    check_resp("decerr write", DECERR, resp);
    axi_write("dram base write", CTRL_BASE + REG_DRAM_BASE, {rand_word(), rand_word()},
              8'hff, resp);
    check_resp("dram base write", SLVERR, resp);
    axi_write("bad offset write", CTRL_BASE + 32'h40, {rand_word(), rand_word()}, 8'hff, resp);
    check_resp("bad offset write", SLVERR, resp);
    axi_read("bad offset read", CTRL_BASE + 32'h40, rd, resp);
    check_resp("bad offset read", SLVERR, resp);
    // register state must be untouched
    check_data("exit kept", exp_exit, exit_o);
    check_data("hw_cnt kept", data_t'(exp_hw), data_t'(hw_cnt_en_o));
    axi_read("dram base read", CTRL_BASE + REG_DRAM_BASE, rd, resp);
    check_data("dram base read", 64'h0000_0000_8000_0000, rd);
    report_test("errors", errs);
  endtask

  initial begin : main
    reset_l     = 1'b0;
    s_awaddr_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_bready_i  = 1'b0;
    s_araddr_i  = '0;
    s_arvalid_i = 1'b0;
    s_rready_i  = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    reset_l = 1'b1;
    test_reset();
    test_ctrl_regs();
    test_event();
    test_noc_writes();
    test_noc_reads();
    test_errors();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_top

/* tb.f */
+incdir+verification
design/fabric_pkg.sv
design/wake_reset_gen.sv
design/axil_addr_decode.sv
design/ctrl_regs.sv
design/noc_bridge.sv
design/axil_resp_stage.sv
design/tile_fabric_top.sv
verification/tb_top.sv
